/* Bender.yml */
package:
  name: storage_subsystem

sources:
  - files:
      - verilog/storage_pkg.sv
      - verilog/sram_1rw1r_256x32.sv
      - verilog/storage_bridge_wb.sv
      - verilog/storage_top.sv
  - target: simulation
    files:
      - tests/storage_clk_gen.sv
      - tests/storage_tb.sv

/* storage_top.f */
verilog/storage_pkg.sv
verilog/sram_1rw1r_256x32.sv
verilog/storage_bridge_wb.sv
verilog/storage_top.sv
tests/storage_clk_gen.sv
tests/storage_tb.sv

/* tests/storage_clk_gen.sv */
`timescale 1ns/1ps

module storage_clk_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 3
) (
    output logic clk_o,
    output logic arst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Released on a falling edge, clear of the flop sampling edge
    initial begin
        arst_n_o = 1'b0;
        #(RESET_CYCLES * PERIOD_NS);
        arst_n_o = 1'b1;
    end

endmodule

/* tests/storage_tb.sv */
`timescale 1ns/1ps

module storage_tb;
    import storage_pkg::*;

    localparam int    CLK_PERIOD = 100;
    localparam int    ACK_LIMIT  = 6;
    localparam string DATA_FILE  = "tests/storage_testdata.txt";

    typedef struct packed {
        logic        is_write;
        logic        lane;
        wb_addr_t    adr;
        byte_mask_t  sel;
        word_t       wdata;
        word_t       exp_data;
        logic [15:0] line_no;
    } access_t;

    logic       wb_clk;
    logic       arst_n;
    logic       wb_cyc;
    logic [1:0] wb_stb;
    logic       wb_we;
    wb_addr_t   wb_adr;
    byte_mask_t wb_sel;
    word_t      wb_dat;
    logic [1:0] wb_ack;
    word_t      wb_rw_dat;
    word_t      wb_ro_dat;

    access_t     tests[$];
    bit          loaded;
    int          checks;
    int          value_errors;
    int          other_errors;
    logic [31:0] lfsr;

    storage_clk_gen #(
        .PERIOD_NS    (CLK_PERIOD),
        .RESET_CYCLES (3)
    ) u_clk_gen (
        .clk_o    (wb_clk),
        .arst_n_o (arst_n)
    );

    storage_top DUT (
        .wb_clk_i    (wb_clk),
        .arst_n_i    (arst_n),
        .wb_cyc_i    (wb_cyc),
        .wb_stb_i    (wb_stb),
        .wb_we_i     (wb_we),
        .wb_adr_i    (wb_adr),
        .wb_sel_i    (wb_sel),
        .wb_dat_i    (wb_dat),
        .wb_ack_o    (wb_ack),
        .wb_rw_dat_o (wb_rw_dat),
        .wb_ro_dat_o (wb_ro_dat)
    );

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // Two bits, one step each
    function automatic int draw_gap();
        int g;
        g = 0;
        for (int b = 0; b < 2; b++) begin
            g = (g << 1) | int'(lfsr[0]);
            lfsr = lfsr_next(lfsr);
        end
        return g;
    endfunction

    task automatic check_word(input string name, input string what,
                              input word_t exp, input word_t act);
        checks++;
        assert (act === exp) else begin
            value_errors++;
            $display("[ERROR] %s %s: expected %08h, actual %08h", name, what, exp, act);
        end
    endtask

    task automatic check_count(input string name, input string what,
                               input int exp, input int act);
        checks++;
        assert (act == exp) else begin
            value_errors++;
            $display("[ERROR] %s %s: expected %0d, actual %0d", name, what, exp, act);
        end
    endtask

    task automatic load_tests();
        int         fd;
        int         n;
        int         line_no;
        int         lane;
        string      line;
        string      op;
        wb_addr_t   adr;
        byte_mask_t sel;
        word_t      wdata;
        word_t      exp;
        access_t    a;
        fd = $fopen(DATA_FILE, "r");
        if (fd == 0) begin
            other_errors++;
            $display("Cannot open %s", DATA_FILE);
            return;
        end
        line_no = 0;
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            line_no++;
            if (line.len() >= 2 && line.getc(0) != "#") begin
                n = $sscanf(line, "%s %h %h %h %h %h", op, lane, adr, sel, wdata, exp);
                if (n != 6 || (op != "W" && op != "R")) begin
                    other_errors++;
                    $display("Malformed data line %0d in %s", line_no, DATA_FILE);
                end else begin
                    a.is_write = (op == "W");
                    a.lane     = lane[0];
                    a.adr      = adr;
                    a.sel      = sel;
                    a.wdata    = wdata;
                    a.exp_data = exp;
                    a.line_no  = line_no[15:0];
                    tests.push_back(a);
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic run_access(input access_t a);
        string name;
        int    cycles;
        int    exp_lat;
        word_t got;
        name = $sformatf("line %0d %s lane %0d @%08h", a.line_no,
                         a.is_write ? "write" : "read", a.lane, a.adr);
        exp_lat = a.is_write ? 1 : 2;
        @(posedge wb_clk);
        wb_cyc <= 1'b1;
        wb_stb <= a.lane ? 2'b10 : 2'b01;
        wb_we  <= a.is_write;
        wb_adr <= a.adr;
        wb_sel <= a.sel;
        wb_dat <= a.wdata;
        cycles = 0;
        do begin
            @(posedge wb_clk);
            cycles++;
            @(negedge wb_clk);
            assert (wb_ack[!a.lane] == 1'b0) else begin
                other_errors++;
                $display("%s: acknowledge raised on the idle lane", name);
            end
        end while (!wb_ack[a.lane] && cycles < ACK_LIMIT);
        assert (wb_ack[a.lane] == 1'b1) else begin
            other_errors++;
            $display("%s: no acknowledge within %0d clocks", name, ACK_LIMIT);
        end
        if (wb_ack[a.lane]) begin
            check_count(name, "ack latency", exp_lat, cycles);
            if (!a.is_write) begin
                got = a.lane ? wb_ro_dat : wb_rw_dat;
                check_word(name, "read data", a.exp_data, got);
            end
        end
        @(posedge wb_clk);
        wb_cyc <= 1'b0;
        wb_stb <= 2'b00;
        wb_we  <= 1'b0;
        @(negedge wb_clk);
        assert (wb_ack == 2'b00) else begin
            other_errors++;
            $display("%s: acknowledge held high for more than one clock", name);
        end
    endtask

    initial begin : main
        int gap;
        wb_cyc <= 1'b0;
        wb_stb <= 2'b00;
        wb_we  <= 1'b0;
        wb_adr <= '0;
        wb_sel <= '0;
        wb_dat <= '0;
        lfsr = 32'h375c_7962;
        load_tests();
        if (tests.size() == 0) begin
            other_errors++;
            $display("No accesses loaded from %s", DATA_FILE);
        end
        loaded = 1'b1;
        @(posedge arst_n);
        @(posedge wb_clk);
        @(negedge wb_clk);
        assert (wb_ack == 2'b00) else begin
            other_errors++;
            $display("Acknowledge high right after reset");
        end
        foreach (tests[i]) begin
            run_access(tests[i]);
            gap = draw_gap();
            repeat (gap) @(posedge wb_clk);
        end
        $display("checks: %0d, value errors: %0d, other errors: %0d",
                 checks, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // Eight clocks per access covers drive, latency, drop and the longest gap
    initial begin : watchdog
        longint limit_ns;
        wait (loaded);
        limit_ns = (longint'(tests.size()) * 8 + 20) * CLK_PERIOD;
        #(limit_ns);
        $display("Watchdog expired: run did not finish within %0d ns", limit_ns);
        $display("tests failed");
        $finish;
    end

endmodule

/* tests/storage_testdata.txt */
# op lane address sel wdata expected (hex); op W write, R read
# lane 0 read/write window, lane 1 read-only window; expected unused for writes
W 0 00000000 f 11111111 00000000
W 0 00100000 f 22222222 00000000
R 0 00000000 f 00000000 11111111
R 0 00100000 f 00000000 22222222
W 0 00000004 f a5a5a5a5 00000000
W 0 001003fc f 5a5a5a5a 00000000
R 0 00000004 f 00000000 a5a5a5a5
R 0 001003fc f 00000000 5a5a5a5a
W 0 00000004 1 000000cc 00000000
R 0 00000004 f 00000000 a5a5a5cc
W 0 00000004 6 00ddee00 00000000
R 0 00000004 f 00000000 a5ddeecc
W 0 001003fc 8 77000000 00000000
R 0 001003fc f 00000000 775a5a5a
R 1 00200004 f 00000000 a5ddeecc
R 1 00200000 f 00000000 11111111
W 1 00200000 f deadbeef 00000000
R 1 00200000 f 00000000 11111111
R 0 00000000 f 00000000 11111111
R 0 00300000 f 00000000 00000000
W 0 00300000 f cafef00d 00000000
R 0 00000000 f 00000000 11111111
R 0 00100000 f 00000000 22222222
R 1 00300000 f 00000000 00000000
R 0 00200000 f 00000000 00000000
W 0 00200000 f 0badf00d 00000000
R 1 00200000 f 00000000 11111111

/* verilog/sram_1rw1r_256x32.sv */
`timescale 1ns/1ps

module sram_1rw1r_256x32 (
    input  logic                    wb_clk_i,

    // Port 0, read/write
    input  storage_pkg::sram_req_t  req_i,
    input  logic                    ena_n_i,
    output storage_pkg::word_t      rdata_o,

    // Port 1, read only
    input  logic                    ro_ena_n_i,
    input  storage_pkg::sram_addr_t ro_addr_i,
    output storage_pkg::word_t      ro_rdata_o
);
    import storage_pkg::*;

    word_t mem [256];

    // Port 0: byte-masked write, otherwise registered read
    always_ff @(posedge wb_clk_i) begin
        if (!ena_n_i) begin
            if (!req_i.wen_n) begin
                for (int b = 0; b < 4; b++) begin
                    if (req_i.wmask[b]) begin
                        mem[req_i.addr][b*8 +: 8] <= req_i.wdata[b*8 +: 8];
                    end
                end
            end else begin
                rdata_o <= mem[req_i.addr];
            end
        end
    end

    // Port 1 sees the old word on a same-cycle write
    always_ff @(posedge wb_clk_i) begin
        if (!ro_ena_n_i) begin
            ro_rdata_o <= mem[ro_addr_i];
        end
    end

    a_write_mask: assert property (
        @(posedge wb_clk_i)
        (!ena_n_i && !req_i.wen_n) |-> (req_i.wmask != '0)
    );

endmodule

/* verilog/storage_bridge_wb.sv */
`timescale 1ns/1ps

module storage_bridge_wb #(
    parameter int N_RW_BLOCKS = 2,
    parameter storage_pkg::region_t [N_RW_BLOCKS-1:0] RW_BASES = {24'h10_0000, 24'h00_0000},
    parameter storage_pkg::region_t RO_BASE = 24'h20_0000
) (
    input  logic                                   wb_clk_i,
    input  logic                                   arst_n_i,

    input  logic                                   wb_cyc_i,
    input  logic [1:0]                             wb_stb_i,
    input  logic                                   wb_we_i,
    input  storage_pkg::wb_addr_t                  wb_adr_i,
    input  storage_pkg::byte_mask_t                wb_sel_i,
    input  storage_pkg::word_t                     wb_dat_i,
    output logic [1:0]                             wb_ack_o,
    output storage_pkg::word_t                     wb_rw_dat_o,
    output storage_pkg::word_t                     wb_ro_dat_o,

    output storage_pkg::sram_req_t                 rw_req_o,
    output logic [N_RW_BLOCKS-1:0]                 rw_ena_n_o,
    input  storage_pkg::word_t [N_RW_BLOCKS-1:0]   rw_rdata_i,

    output logic                                   ro_ena_n_o,
    output storage_pkg::sram_addr_t                ro_addr_o,
    input  storage_pkg::word_t                     ro_rdata_i
);
    import storage_pkg::*;

    logic [1:0]             valid;
    logic [1:0]             accept;
    region_t                masked_adr;
    logic [N_RW_BLOCKS-1:0] rw_hit;
    logic                   ro_hit;
    logic [N_RW_BLOCKS-1:0] rw_sel_q;
    logic                   ro_sel_q;

    assign valid      = {2{wb_cyc_i}} & wb_stb_i;
    assign masked_adr = wb_adr_i[23:0] & REGION_MASK;

    // One acknowledge FSM per lane
    for (genvar l = 0; l < 2; l++) begin : g_lane
        bridge_state_e state_q;

        assign accept[l]   = valid[l] && (state_q == ST_IDLE);
        assign wb_ack_o[l] = (state_q == ST_ACK);

        always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
            if (!arst_n_i) begin
                state_q <= ST_IDLE;
            end else begin
                case (state_q)
                    ST_IDLE: begin
                        if (valid[l]) begin
                            state_q <= wb_we_i ? ST_ACK : ST_RD_WAIT;
                        end
                    end
                    // SRAM output registered during this cycle
                    ST_RD_WAIT: state_q <= ST_ACK;
                    ST_ACK:     state_q <= ST_IDLE;
                    default:    state_q <= ST_IDLE;
                endcase
            end
        end

        // Acknowledge only while the master still holds its strobe
        a_ack_pulse: assert property (
            @(posedge wb_clk_i) disable iff (!arst_n_i)
            wb_ack_o[l] |-> valid[l]
        );
    end

    // Region decode
    for (genvar i = 0; i < N_RW_BLOCKS; i++) begin : g_decode
        assign rw_hit[i] = (masked_adr == RW_BASES[i]);
    end

    assign ro_hit = (masked_adr == RO_BASE);

    // Read/write port shared by all banks
    assign rw_req_o.wen_n = ~(wb_we_i & valid[0]);
    assign rw_req_o.wmask = wb_sel_i;
    assign rw_req_o.addr  = wb_adr_i[9:2];
    assign rw_req_o.wdata = wb_dat_i;
    assign rw_ena_n_o     = accept[0] ? ~rw_hit : '1;

    // Read-only port of bank 0
    assign ro_ena_n_o = ~(accept[1] & ro_hit);
    assign ro_addr_o  = wb_adr_i[9:2];

    // Bank select held until the next accepted access
    always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rw_sel_q <= '0;
            ro_sel_q <= 1'b0;
        end else begin
            if (accept[0]) begin
                rw_sel_q <= rw_hit;
            end
            if (accept[1]) begin
                ro_sel_q <= ro_hit;
            end
        end
    end

    // Unmapped region leaves select empty so zero comes back
    always_comb begin
        wb_rw_dat_o = '0;
        for (int i = 0; i < N_RW_BLOCKS; i++) begin
            if (rw_sel_q[i]) begin
                wb_rw_dat_o = wb_rw_dat_o | rw_rdata_i[i];
            end
        end
    end

    assign wb_ro_dat_o = ro_sel_q ? ro_rdata_i : '0;

    // Bases must not overlap
    a_one_bank: assert property (
        @(posedge wb_clk_i) disable iff (!arst_n_i)
        $countones(~rw_ena_n_o) <= 1
    );

endmodule

/* verilog/storage_pkg.sv */
package storage_pkg;

    // Bus and SRAM data
    typedef logic [31:0] word_t;

    // Wishbone byte address
    typedef logic [31:0] wb_addr_t;

    // SRAM word address, bus address bits 9:2
    typedef logic [7:0] sram_addr_t;

    // One bit per byte lane, active high
    typedef logic [3:0] byte_mask_t;

    // Region base, compared against masked low address bits
    typedef logic [23:0] region_t;

    localparam region_t REGION_MASK = 24'hFF_0000;

    // Shared request to all banks
    typedef struct packed {
        logic       wen_n;
        byte_mask_t wmask;
        sram_addr_t addr;
        word_t      wdata;
    } sram_req_t;

    // Per-lane acknowledge FSM
    typedef enum logic [1:0] {
        ST_IDLE    = 2'b00,
        ST_RD_WAIT = 2'b01,
        ST_ACK     = 2'b10
    } bridge_state_e;

endpackage

/* verilog/storage_top.sv */
`timescale 1ns/1ps

module storage_top #(
    parameter int N_RW_BLOCKS = 2,
    parameter storage_pkg::region_t [N_RW_BLOCKS-1:0] RW_BASES = {24'h10_0000, 24'h00_0000},
    parameter storage_pkg::region_t RO_BASE = 24'h20_0000
) (
    input  logic                    wb_clk_i,
    input  logic                    arst_n_i,

    input  logic                    wb_cyc_i,
    input  logic [1:0]              wb_stb_i,
    input  logic                    wb_we_i,
    input  storage_pkg::wb_addr_t   wb_adr_i,
    input  storage_pkg::byte_mask_t wb_sel_i,
    input  storage_pkg::word_t      wb_dat_i,
    output logic [1:0]              wb_ack_o,
    output storage_pkg::word_t      wb_rw_dat_o,
    output storage_pkg::word_t      wb_ro_dat_o
);
    import storage_pkg::*;

    sram_req_t                rw_req;
    logic [N_RW_BLOCKS-1:0]   rw_ena_n;
    word_t [N_RW_BLOCKS-1:0]  rw_rdata;
    logic                     ro_ena_n;
    sram_addr_t               ro_addr;
    word_t [N_RW_BLOCKS-1:0]  bank_ro_rdata;

    storage_bridge_wb #(
        .N_RW_BLOCKS (N_RW_BLOCKS),
        .RW_BASES    (RW_BASES),
        .RO_BASE     (RO_BASE)
    ) u_bridge (
        .wb_clk_i    (wb_clk_i),
        .arst_n_i    (arst_n_i),
        .wb_cyc_i    (wb_cyc_i),
        .wb_stb_i    (wb_stb_i),
        .wb_we_i     (wb_we_i),
        .wb_adr_i    (wb_adr_i),
        .wb_sel_i    (wb_sel_i),
        .wb_dat_i    (wb_dat_i),
        .wb_ack_o    (wb_ack_o),
        .wb_rw_dat_o (wb_rw_dat_o),
        .wb_ro_dat_o (wb_ro_dat_o),
        .rw_req_o    (rw_req),
        .rw_ena_n_o  (rw_ena_n),
        .rw_rdata_i  (rw_rdata),
        .ro_ena_n_o  (ro_ena_n),
        .ro_addr_o   (ro_addr),
        .ro_rdata_i  (bank_ro_rdata[0])
    );

    for (genvar i = 0; i < N_RW_BLOCKS; i++) begin : g_bank
        // Only bank 0 has its second port in use
        sram_1rw1r_256x32 u_sram (
            .wb_clk_i   (wb_clk_i),
            .req_i      (rw_req),
            .ena_n_i    (rw_ena_n[i]),
            .rdata_o    (rw_rdata[i]),
            .ro_ena_n_i ((i == 0) ? ro_ena_n : 1'b1),
            .ro_addr_i  ((i == 0) ? ro_addr : '0),
            .ro_rdata_o (bank_ro_rdata[i])
        );
    end

endmodule
